// ==== all.f ====
src/udp_ip_pkg.sv
src/ip_proto_demux.sv
src/ip_tx_arbiter.sv
src/udp_ip_switch.sv
tests/udp_ip_switch_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, result taken from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module udp_ip_switch_tb -f all.f -o sim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/sim > sim.log 2>&1
grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== tests/udp_ip_switch_tb.sv ====
`timescale 1ns/100ps

module udp_ip_switch_tb
    import udp_ip_pkg::*;
();

localparam int RX_FRAMES  = 40;
localparam int TX_FRAMES  = 20;
localparam int MAX_BYTES  = 16;
localparam longint WATCH_NS = (RX_FRAMES + 2 * TX_FRAMES) * 17 * 4 * 10 + 20000;

logic clk = 1'b0;
logic rst;
logic post_rst = 1'b1;
logic [31:0] seed = 32'h7bafd527;

logic rx_in_hdr_valid, rx_in_hdr_ready, rx_in_payload_tvalid, rx_in_payload_tready;
logic rx_in_payload_tlast, rx_in_payload_tuser;
ip_dscp_t rx_in_dscp;
ip_ecn_t rx_in_ecn;
ip_len_t rx_in_length;
ip_ttl_t rx_in_ttl;
ip_proto_t rx_in_protocol;
ip_addr_t rx_in_source_ip, rx_in_dest_ip;
axis_byte_t rx_in_payload_tdata;

logic udp_rx_hdr_valid, udp_rx_payload_tvalid;
logic udp_rx_hdr_ready = 1'b0;
logic udp_rx_payload_tready = 1'b0;
logic udp_rx_payload_tlast, udp_rx_payload_tuser;
ip_dscp_t udp_rx_dscp;
ip_ecn_t udp_rx_ecn;
ip_len_t udp_rx_length;
ip_ttl_t udp_rx_ttl;
ip_proto_t udp_rx_protocol;
ip_addr_t udp_rx_source_ip, udp_rx_dest_ip;
axis_byte_t udp_rx_payload_tdata;

logic raw_rx_hdr_valid, raw_rx_payload_tvalid;
logic raw_rx_hdr_ready = 1'b0;
logic raw_rx_payload_tready = 1'b0;
logic raw_rx_payload_tlast, raw_rx_payload_tuser;
ip_dscp_t raw_rx_dscp;
ip_ecn_t raw_rx_ecn;
ip_len_t raw_rx_length;
ip_ttl_t raw_rx_ttl;
ip_proto_t raw_rx_protocol;
ip_addr_t raw_rx_source_ip, raw_rx_dest_ip;
axis_byte_t raw_rx_payload_tdata;

logic udp_tx_hdr_valid, udp_tx_hdr_ready, udp_tx_payload_tvalid, udp_tx_payload_tready;
logic udp_tx_payload_tlast, udp_tx_payload_tuser;
ip_dscp_t udp_tx_dscp;
ip_ecn_t udp_tx_ecn;
ip_len_t udp_tx_length;
ip_ttl_t udp_tx_ttl;
ip_addr_t udp_tx_source_ip, udp_tx_dest_ip;
axis_byte_t udp_tx_payload_tdata;

logic raw_tx_hdr_valid, raw_tx_hdr_ready, raw_tx_payload_tvalid, raw_tx_payload_tready;
logic raw_tx_payload_tlast, raw_tx_payload_tuser;
ip_dscp_t raw_tx_dscp;
ip_ecn_t raw_tx_ecn;
ip_len_t raw_tx_length;
ip_ttl_t raw_tx_ttl;
ip_proto_t raw_tx_protocol;
ip_addr_t raw_tx_source_ip, raw_tx_dest_ip;
axis_byte_t raw_tx_payload_tdata;

logic tx_out_hdr_valid, tx_out_payload_tvalid;
logic tx_out_hdr_ready = 1'b0;
logic tx_out_payload_tready = 1'b0;
logic tx_out_payload_tlast, tx_out_payload_tuser;
ip_dscp_t tx_out_dscp;
ip_ecn_t tx_out_ecn;
ip_len_t tx_out_length;
ip_ttl_t tx_out_ttl;
ip_proto_t tx_out_protocol;
ip_addr_t tx_out_source_ip, tx_out_dest_ip;
axis_byte_t tx_out_payload_tdata;

// Header packed as dscp, ecn, length, ttl, protocol, source, destination
logic [103:0] udp_rx_hq[$], raw_rx_hq[$], udp_tx_hq[$], raw_tx_hq[$];
// Beat packed as tuser, tlast, data
logic [9:0] udp_rx_bq[$], raw_rx_bq[$], udp_tx_bq[$], raw_tx_bq[$];

logic udp_rx_active = 1'b0;
logic raw_rx_active = 1'b0;
int   tx_src = 0;

udp_ip_switch udp_ip_switch_inst (.*);

always #5 clk = ~clk;

function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
endfunction

task automatic report_value(input string name, input logic [103:0] exp, input logic [103:0] act);
    $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    $display("RESULT: FAIL");
    $fatal(1);
endtask

task automatic report_error(input string msg);
    $display("Error at t=%0t: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1);
endtask

task automatic drive_hdr(input int port, input logic [103:0] h, input logic v);
    case (port)
        0: begin
            rx_in_hdr_valid <= v;
            {rx_in_dscp, rx_in_ecn, rx_in_length, rx_in_ttl} <= h[103:72];
            {rx_in_protocol, rx_in_source_ip, rx_in_dest_ip} <= h[71:0];
        end
        1: begin
            udp_tx_hdr_valid <= v;
            {udp_tx_dscp, udp_tx_ecn, udp_tx_length, udp_tx_ttl} <= h[103:72];
            {udp_tx_source_ip, udp_tx_dest_ip} <= h[63:0];
        end
        default: begin
            raw_tx_hdr_valid <= v;
            {raw_tx_dscp, raw_tx_ecn, raw_tx_length, raw_tx_ttl} <= h[103:72];
            {raw_tx_protocol, raw_tx_source_ip, raw_tx_dest_ip} <= h[71:0];
        end
    endcase
endtask

task automatic drive_beat(input int port, input logic [9:0] b, input logic v);
    case (port)
        0: begin
            rx_in_payload_tvalid <= v;
            {rx_in_payload_tuser, rx_in_payload_tlast, rx_in_payload_tdata} <= b;
        end
        1: begin
            udp_tx_payload_tvalid <= v;
            {udp_tx_payload_tuser, udp_tx_payload_tlast, udp_tx_payload_tdata} <= b;
        end
        default: begin
            raw_tx_payload_tvalid <= v;
            {raw_tx_payload_tuser, raw_tx_payload_tlast, raw_tx_payload_tdata} <= b;
        end
    endcase
endtask

// Returns just after the edge on which the handshake completed
task automatic wait_transfer(input int port, input logic payload);
    logic fire;
    do begin
        @(negedge clk);
        case (port)
            0: fire = payload ? rx_in_payload_tvalid && rx_in_payload_tready
                              : rx_in_hdr_valid && rx_in_hdr_ready;
            1: fire = payload ? udp_tx_payload_tvalid && udp_tx_payload_tready
                              : udp_tx_hdr_valid && udp_tx_hdr_ready;
            default: fire = payload ? raw_tx_payload_tvalid && raw_tx_payload_tready
                                    : raw_tx_hdr_valid && raw_tx_hdr_ready;
        endcase
        @(posedge clk);
    end while (!fire);
endtask

task automatic idle_gap(input int port, input logic payload);
    logic [31:0] r;
    r = next_rand();
    if (r[1:0] == 2'b00) begin
        if (payload) begin
            drive_beat(port, 10'h0, 1'b0);
        end else begin
            drive_hdr(port, 104'h0, 1'b0);
        end
        repeat (1 + int'(r[2])) @(posedge clk);
    end
endtask

// Port 0 is rx_in, 1 is udp_tx, 2 is raw_tx
task automatic send_frame(input int port, input int idx);
    logic [31:0] r1, r2, r3, r4;
    logic [7:0]  proto;
    logic [103:0] h;
    logic [9:0]  b;
    logic        to_udp;
    int          len;
    if (idx > 0) begin
        idle_gap(port, 1'b0);
    end
    r1 = next_rand();
    r2 = next_rand();
    r3 = next_rand();
    r4 = next_rand();
    if (port == 1 || (port == 0 && r2[31])) begin
        proto = 8'h11;
    end else begin
        proto = r2[30] ? 8'h06 : 8'h01;
    end
    to_udp = (proto == 8'h11);
    h = {r1[5:0], r1[7:6], r1[23:8], r2[7:0], proto, r3, r4};
    len = int'(r2[11:8]) + 1;
    if (port == 0 && to_udp) udp_rx_hq.push_back(h);
    else if (port == 0) raw_rx_hq.push_back(h);
    else if (port == 1) udp_tx_hq.push_back(h);
    else raw_tx_hq.push_back(h);
    drive_hdr(port, h, 1'b1);
    wait_transfer(port, 1'b0);
    // Header fields no longer meaningful once taken
    drive_hdr(port, 104'h0, 1'b0);
    for (int i = 0; i < len; i++) begin
        if (i > 0) begin
            idle_gap(port, 1'b1);
        end
        r1 = next_rand();
        b = {r1[16], i == len - 1, r1[7:0]};
        if (port == 0 && to_udp) udp_rx_bq.push_back(b);
        else if (port == 0) raw_rx_bq.push_back(b);
        else if (port == 1) udp_tx_bq.push_back(b);
        else raw_tx_bq.push_back(b);
        drive_beat(port, b, 1'b1);
        wait_transfer(port, 1'b1);
    end
    drive_beat(port, 10'h0, 1'b0);
endtask

// Random back-pressure on all outputs, ready high three times in four
always @(posedge clk) begin
    logic [31:0] r;
    r = next_rand();
    udp_rx_hdr_ready      <= |r[1:0];
    udp_rx_payload_tready <= |r[3:2];
    raw_rx_hdr_ready      <= |r[5:4];
    raw_rx_payload_tready <= |r[7:6];
    tx_out_hdr_ready      <= |r[9:8];
    tx_out_payload_tready <= |r[11:10];
    post_rst <= rst;
end

always @(negedge clk) begin
    logic [103:0] exp;
    if (rst || post_rst) begin
        assert (!(udp_rx_hdr_valid || raw_rx_hdr_valid || tx_out_hdr_valid ||
                  udp_rx_payload_tvalid || raw_rx_payload_tvalid || tx_out_payload_tvalid))
            else report_error("valid output high during or just after reset");
    end else begin
        assert (!(udp_rx_active && (raw_rx_hdr_valid || raw_rx_payload_tvalid)))
            else report_error("raw_rx valid during a UDP frame");
        assert (!(raw_rx_active && (udp_rx_hdr_valid || udp_rx_payload_tvalid)))
            else report_error("udp_rx valid during a raw frame");
        assert (!(tx_out_hdr_valid && udp_tx_hdr_valid) || tx_out_protocol == IP_PROTO_UDP)
            else report_value("tx_out_protocol", 104'(IP_PROTO_UDP), 104'(tx_out_protocol));

        if (udp_rx_hdr_valid && udp_rx_hdr_ready) begin
            if (udp_rx_hq.size() == 0) report_error("unexpected header on udp_rx");
            exp = udp_rx_hq.pop_front();
            assert ({udp_rx_dscp, udp_rx_ecn, udp_rx_length, udp_rx_ttl, udp_rx_protocol,
                     udp_rx_source_ip, udp_rx_dest_ip} == exp)
                else report_value("udp_rx header", exp, {udp_rx_dscp, udp_rx_ecn,
                    udp_rx_length, udp_rx_ttl, udp_rx_protocol, udp_rx_source_ip,
                    udp_rx_dest_ip});
            udp_rx_active = 1'b1;
        end
        if (udp_rx_payload_tvalid && udp_rx_payload_tready) begin
            if (udp_rx_bq.size() == 0) report_error("unexpected payload beat on udp_rx");
            exp = 104'(udp_rx_bq.pop_front());
            assert ({udp_rx_payload_tuser, udp_rx_payload_tlast, udp_rx_payload_tdata} ==
                    exp[9:0])
                else report_value("udp_rx payload", exp, 104'({udp_rx_payload_tuser,
                    udp_rx_payload_tlast, udp_rx_payload_tdata}));
            if (udp_rx_payload_tlast) udp_rx_active = 1'b0;
        end

        if (raw_rx_hdr_valid && raw_rx_hdr_ready) begin
            if (raw_rx_hq.size() == 0) report_error("unexpected header on raw_rx");
            exp = raw_rx_hq.pop_front();
            assert ({raw_rx_dscp, raw_rx_ecn, raw_rx_length, raw_rx_ttl, raw_rx_protocol,
                     raw_rx_source_ip, raw_rx_dest_ip} == exp)
                else report_value("raw_rx header", exp, {raw_rx_dscp, raw_rx_ecn,
                    raw_rx_length, raw_rx_ttl, raw_rx_protocol, raw_rx_source_ip,
                    raw_rx_dest_ip});
            raw_rx_active = 1'b1;
        end
        if (raw_rx_payload_tvalid && raw_rx_payload_tready) begin
            if (raw_rx_bq.size() == 0) report_error("unexpected payload beat on raw_rx");
            exp = 104'(raw_rx_bq.pop_front());
            assert ({raw_rx_payload_tuser, raw_rx_payload_tlast, raw_rx_payload_tdata} ==
                    exp[9:0])
                else report_value("raw_rx payload", exp, 104'({raw_rx_payload_tuser,
                    raw_rx_payload_tlast, raw_rx_payload_tdata}));
            if (raw_rx_payload_tlast) raw_rx_active = 1'b0;
        end

        // UDP wins whenever its header is valid
        if (tx_out_hdr_valid && tx_out_hdr_ready) begin
            tx_src = udp_tx_hdr_valid ? 1 : 2;
            if (tx_src == 1 && udp_tx_hq.size() == 0) report_error("extra UDP frame on tx_out");
            if (tx_src == 2 && raw_tx_hq.size() == 0) report_error("extra raw frame on tx_out");
            exp = (tx_src == 1) ? udp_tx_hq.pop_front() : raw_tx_hq.pop_front();
            assert ({tx_out_dscp, tx_out_ecn, tx_out_length, tx_out_ttl, tx_out_protocol,
                     tx_out_source_ip, tx_out_dest_ip} == exp)
                else report_value("tx_out header", exp, {tx_out_dscp, tx_out_ecn,
                    tx_out_length, tx_out_ttl, tx_out_protocol, tx_out_source_ip,
                    tx_out_dest_ip});
        end
        if (tx_out_payload_tvalid && tx_out_payload_tready) begin
            if (tx_src == 0) report_error("payload beat on tx_out without a granted header");
            if ((tx_src == 1 ? udp_tx_bq.size() : raw_tx_bq.size()) == 0) begin
                report_error("unexpected payload beat on tx_out");
            end
            exp = 104'((tx_src == 1) ? udp_tx_bq.pop_front() : raw_tx_bq.pop_front());
            assert ({tx_out_payload_tuser, tx_out_payload_tlast, tx_out_payload_tdata} ==
                    exp[9:0])
                else report_value("tx_out payload", exp, 104'({tx_out_payload_tuser,
                    tx_out_payload_tlast, tx_out_payload_tdata}));
            if (tx_out_payload_tlast) tx_src = 0;
        end
    end
end

initial begin
    #(WATCH_NS * 1ns);
    $display("Timeout: frames did not finish in %0d ns", WATCH_NS);
    $display("RESULT: FAIL");
    $fatal(1);
end

initial begin
    rst <= 1'b1;
    drive_hdr(0, 104'h0, 1'b0);
    drive_hdr(1, 104'h0, 1'b0);
    drive_hdr(2, 104'h0, 1'b0);
    // Stray payload valid during reset must not leave the idle route
    drive_beat(0, 10'h0, 1'b1);
    drive_beat(1, 10'h0, 1'b1);
    drive_beat(2, 10'h0, 1'b1);
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    drive_beat(0, 10'h0, 1'b0);
    drive_beat(1, 10'h0, 1'b0);
    drive_beat(2, 10'h0, 1'b0);
    @(posedge clk);
    // First UDP and raw transmit headers start together
    fork
        for (int i = 0; i < RX_FRAMES; i++) send_frame(0, i);
        for (int i = 0; i < TX_FRAMES; i++) send_frame(1, i);
        for (int i = 0; i < TX_FRAMES; i++) send_frame(2, i);
    join
    @(negedge clk);
    if (udp_rx_hq.size() + raw_rx_hq.size() + udp_tx_hq.size() + raw_tx_hq.size() +
        udp_rx_bq.size() + raw_rx_bq.size() + udp_tx_bq.size() + raw_tx_bq.size() != 0) begin
        report_error("expected frames left undelivered");
    end else begin
        $display("RESULT: PASS");
        $finish;
    end
end

endmodule

// ==== src/udp_ip_switch.sv ====
`timescale 1ns/100ps

module udp_ip_switch
    import udp_ip_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Received frames from the IP stack
    input  logic       rx_in_hdr_valid,
    output logic       rx_in_hdr_ready,
    input  ip_dscp_t   rx_in_dscp,
    input  ip_ecn_t    rx_in_ecn,
    input  ip_len_t    rx_in_length,
    input  ip_ttl_t    rx_in_ttl,
    input  ip_proto_t  rx_in_protocol,
    input  ip_addr_t   rx_in_source_ip,
    input  ip_addr_t   rx_in_dest_ip,
    input  axis_byte_t rx_in_payload_tdata,
    input  logic       rx_in_payload_tvalid,
    output logic       rx_in_payload_tready,
    input  logic       rx_in_payload_tlast,
    input  logic       rx_in_payload_tuser,

    // Received UDP frames
    output logic       udp_rx_hdr_valid,
    input  logic       udp_rx_hdr_ready,
    output ip_dscp_t   udp_rx_dscp,
    output ip_ecn_t    udp_rx_ecn,
    output ip_len_t    udp_rx_length,
    output ip_ttl_t    udp_rx_ttl,
    output ip_proto_t  udp_rx_protocol,
    output ip_addr_t   udp_rx_source_ip,
    output ip_addr_t   udp_rx_dest_ip,
    output axis_byte_t udp_rx_payload_tdata,
    output logic       udp_rx_payload_tvalid,
    input  logic       udp_rx_payload_tready,
    output logic       udp_rx_payload_tlast,
    output logic       udp_rx_payload_tuser,

    // Received raw IP frames
    output logic       raw_rx_hdr_valid,
    input  logic       raw_rx_hdr_ready,
    output ip_dscp_t   raw_rx_dscp,
    output ip_ecn_t    raw_rx_ecn,
    output ip_len_t    raw_rx_length,
    output ip_ttl_t    raw_rx_ttl,
    output ip_proto_t  raw_rx_protocol,
    output ip_addr_t   raw_rx_source_ip,
    output ip_addr_t   raw_rx_dest_ip,
    output axis_byte_t raw_rx_payload_tdata,
    output logic       raw_rx_payload_tvalid,
    input  logic       raw_rx_payload_tready,
    output logic       raw_rx_payload_tlast,
    output logic       raw_rx_payload_tuser,

    // Transmit from the UDP engine
    input  logic       udp_tx_hdr_valid,
    output logic       udp_tx_hdr_ready,
    input  ip_dscp_t   udp_tx_dscp,
    input  ip_ecn_t    udp_tx_ecn,
    input  ip_len_t    udp_tx_length,
    input  ip_ttl_t    udp_tx_ttl,
    input  ip_addr_t   udp_tx_source_ip,
    input  ip_addr_t   udp_tx_dest_ip,
    input  axis_byte_t udp_tx_payload_tdata,
    input  logic       udp_tx_payload_tvalid,
    output logic       udp_tx_payload_tready,
    input  logic       udp_tx_payload_tlast,
    input  logic       udp_tx_payload_tuser,

    // Transmit from the raw IP user
    input  logic       raw_tx_hdr_valid,
    output logic       raw_tx_hdr_ready,
    input  ip_dscp_t   raw_tx_dscp,
    input  ip_ecn_t    raw_tx_ecn,
    input  ip_len_t    raw_tx_length,
    input  ip_ttl_t    raw_tx_ttl,
    input  ip_proto_t  raw_tx_protocol,
    input  ip_addr_t   raw_tx_source_ip,
    input  ip_addr_t   raw_tx_dest_ip,
    input  axis_byte_t raw_tx_payload_tdata,
    input  logic       raw_tx_payload_tvalid,
    output logic       raw_tx_payload_tready,
    input  logic       raw_tx_payload_tlast,
    input  logic       raw_tx_payload_tuser,

    // Merged transmit toward the IP stack
    output logic       tx_out_hdr_valid,
    input  logic       tx_out_hdr_ready,
    output ip_dscp_t   tx_out_dscp,
    output ip_ecn_t    tx_out_ecn,
    output ip_len_t    tx_out_length,
    output ip_ttl_t    tx_out_ttl,
    output ip_proto_t  tx_out_protocol,
    output ip_addr_t   tx_out_source_ip,
    output ip_addr_t   tx_out_dest_ip,
    output axis_byte_t tx_out_payload_tdata,
    output logic       tx_out_payload_tvalid,
    input  logic       tx_out_payload_tready,
    output logic       tx_out_payload_tlast,
    output logic       tx_out_payload_tuser
);

// Header fields and payload data shared by both receive outputs
assign udp_rx_dscp          = rx_in_dscp;
assign udp_rx_ecn           = rx_in_ecn;
assign udp_rx_length        = rx_in_length;
assign udp_rx_ttl           = rx_in_ttl;
assign udp_rx_protocol      = rx_in_protocol;
assign udp_rx_source_ip     = rx_in_source_ip;
assign udp_rx_dest_ip       = rx_in_dest_ip;
assign udp_rx_payload_tdata = rx_in_payload_tdata;
assign udp_rx_payload_tlast = rx_in_payload_tlast;
assign udp_rx_payload_tuser = rx_in_payload_tuser;

assign raw_rx_dscp          = rx_in_dscp;
assign raw_rx_ecn           = rx_in_ecn;
assign raw_rx_length        = rx_in_length;
assign raw_rx_ttl           = rx_in_ttl;
assign raw_rx_protocol      = rx_in_protocol;
assign raw_rx_source_ip     = rx_in_source_ip;
assign raw_rx_dest_ip       = rx_in_dest_ip;
assign raw_rx_payload_tdata = rx_in_payload_tdata;
assign raw_rx_payload_tlast = rx_in_payload_tlast;
assign raw_rx_payload_tuser = rx_in_payload_tuser;

ip_proto_demux demux_inst (
    .clk                (clk),
    .rst                (rst),
    .in_hdr_valid       (rx_in_hdr_valid),
    .in_hdr_ready       (rx_in_hdr_ready),
    .in_dscp            (rx_in_dscp),
    .in_ecn             (rx_in_ecn),
    .in_length          (rx_in_length),
    .in_ttl             (rx_in_ttl),
    .in_protocol        (rx_in_protocol),
    .in_source_ip       (rx_in_source_ip),
    .in_dest_ip         (rx_in_dest_ip),
    .in_payload_tdata   (rx_in_payload_tdata),
    .in_payload_tvalid  (rx_in_payload_tvalid),
    .in_payload_tready  (rx_in_payload_tready),
    .in_payload_tlast   (rx_in_payload_tlast),
    .in_payload_tuser   (rx_in_payload_tuser),
    .udp_hdr_valid      (udp_rx_hdr_valid),
    .udp_hdr_ready      (udp_rx_hdr_ready),
    .udp_payload_tvalid (udp_rx_payload_tvalid),
    .udp_payload_tready (udp_rx_payload_tready),
    .raw_hdr_valid      (raw_rx_hdr_valid),
    .raw_hdr_ready      (raw_rx_hdr_ready),
    .raw_payload_tvalid (raw_rx_payload_tvalid),
    .raw_payload_tready (raw_rx_payload_tready)
);

ip_tx_arbiter arb_inst (
    .clk                (clk),
    .rst                (rst),
    .udp_hdr_valid      (udp_tx_hdr_valid),
    .udp_hdr_ready      (udp_tx_hdr_ready),
    .udp_dscp           (udp_tx_dscp),
    .udp_ecn            (udp_tx_ecn),
    .udp_length         (udp_tx_length),
    .udp_ttl            (udp_tx_ttl),
    .udp_source_ip      (udp_tx_source_ip),
    .udp_dest_ip        (udp_tx_dest_ip),
    .udp_payload_tdata  (udp_tx_payload_tdata),
    .udp_payload_tvalid (udp_tx_payload_tvalid),
    .udp_payload_tready (udp_tx_payload_tready),
    .udp_payload_tlast  (udp_tx_payload_tlast),
    .udp_payload_tuser  (udp_tx_payload_tuser),
    .raw_hdr_valid      (raw_tx_hdr_valid),
    .raw_hdr_ready      (raw_tx_hdr_ready),
    .raw_dscp           (raw_tx_dscp),
    .raw_ecn            (raw_tx_ecn),
    .raw_length         (raw_tx_length),
    .raw_ttl            (raw_tx_ttl),
    .raw_protocol       (raw_tx_protocol),
    .raw_source_ip      (raw_tx_source_ip),
    .raw_dest_ip        (raw_tx_dest_ip),
    .raw_payload_tdata  (raw_tx_payload_tdata),
    .raw_payload_tvalid (raw_tx_payload_tvalid),
    .raw_payload_tready (raw_tx_payload_tready),
    .raw_payload_tlast  (raw_tx_payload_tlast),
    .raw_payload_tuser  (raw_tx_payload_tuser),
    .out_hdr_valid      (tx_out_hdr_valid),
    .out_hdr_ready      (tx_out_hdr_ready),
    .out_dscp           (tx_out_dscp),
    .out_ecn            (tx_out_ecn),
    .out_length         (tx_out_length),
    .out_ttl            (tx_out_ttl),
    .out_protocol       (tx_out_protocol),
    .out_source_ip      (tx_out_source_ip),
    .out_dest_ip        (tx_out_dest_ip),
    .out_payload_tdata  (tx_out_payload_tdata),
    .out_payload_tvalid (tx_out_payload_tvalid),
    .out_payload_tready (tx_out_payload_tready),
    .out_payload_tlast  (tx_out_payload_tlast),
    .out_payload_tuser  (tx_out_payload_tuser)
);

endmodule

// ==== src/ip_tx_arbiter.sv ====
`timescale 1ns/100ps

module ip_tx_arbiter
    import udp_ip_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // UDP engine transmit, protocol implied
    input  logic       udp_hdr_valid,
    output logic       udp_hdr_ready,
    input  ip_dscp_t   udp_dscp,
    input  ip_ecn_t    udp_ecn,
    input  ip_len_t    udp_length,
    input  ip_ttl_t    udp_ttl,
    input  ip_addr_t   udp_source_ip,
    input  ip_addr_t   udp_dest_ip,
    input  axis_byte_t udp_payload_tdata,
    input  logic       udp_payload_tvalid,
    output logic       udp_payload_tready,
    input  logic       udp_payload_tlast,
    input  logic       udp_payload_tuser,

    // Raw IP user transmit
    input  logic       raw_hdr_valid,
    output logic       raw_hdr_ready,
    input  ip_dscp_t   raw_dscp,
    input  ip_ecn_t    raw_ecn,
    input  ip_len_t    raw_length,
    input  ip_ttl_t    raw_ttl,
    input  ip_proto_t  raw_protocol,
    input  ip_addr_t   raw_source_ip,
    input  ip_addr_t   raw_dest_ip,
    input  axis_byte_t raw_payload_tdata,
    input  logic       raw_payload_tvalid,
    output logic       raw_payload_tready,
    input  logic       raw_payload_tlast,
    input  logic       raw_payload_tuser,

    // Merged stream toward the IP stack
    output logic       out_hdr_valid,
    input  logic       out_hdr_ready,
    output ip_dscp_t   out_dscp,
    output ip_ecn_t    out_ecn,
    output ip_len_t    out_length,
    output ip_ttl_t    out_ttl,
    output ip_proto_t  out_protocol,
    output ip_addr_t   out_source_ip,
    output ip_addr_t   out_dest_ip,
    output axis_byte_t out_payload_tdata,
    output logic       out_payload_tvalid,
    input  logic       out_payload_tready,
    output logic       out_payload_tlast,
    output logic       out_payload_tuser
);

arb_state_t state;
arb_state_t state_next;
logic       idle;
logic       hdr_sel_udp;
logic       pay_sel_udp;
logic       hdr_fire;
logic       last_fire;

assign idle = (state == ARB_IDLE);

// UDP wins whenever its header is valid
assign hdr_sel_udp = udp_hdr_valid;

assign out_hdr_valid = idle && (udp_hdr_valid || raw_hdr_valid);
assign udp_hdr_ready = idle && out_hdr_ready;
assign raw_hdr_ready = idle && !udp_hdr_valid && out_hdr_ready;

always_comb begin
    if (hdr_sel_udp) begin
        out_dscp      = udp_dscp;
        out_ecn       = udp_ecn;
        out_length    = udp_length;
        out_ttl       = udp_ttl;
        out_protocol  = IP_PROTO_UDP;
        out_source_ip = udp_source_ip;
        out_dest_ip   = udp_dest_ip;
    end else begin
        out_dscp      = raw_dscp;
        out_ecn       = raw_ecn;
        out_length    = raw_length;
        out_ttl       = raw_ttl;
        out_protocol  = raw_protocol;
        out_source_ip = raw_source_ip;
        out_dest_ip   = raw_dest_ip;
    end
end

// Payload follows the held grant
assign pay_sel_udp = (state == ARB_UDP);

assign out_payload_tdata  = pay_sel_udp ? udp_payload_tdata : raw_payload_tdata;
assign out_payload_tlast  = pay_sel_udp ? udp_payload_tlast : raw_payload_tlast;
assign out_payload_tuser  = pay_sel_udp ? udp_payload_tuser : raw_payload_tuser;
assign out_payload_tvalid = (pay_sel_udp && udp_payload_tvalid) ||
                            ((state == ARB_RAW) && raw_payload_tvalid);

assign udp_payload_tready = pay_sel_udp && out_payload_tready;
assign raw_payload_tready = (state == ARB_RAW) && out_payload_tready;

assign hdr_fire  = out_hdr_valid && out_hdr_ready;
assign last_fire = out_payload_tvalid && out_payload_tready && out_payload_tlast;

always_comb begin
    state_next = state;
    case (state)
        ARB_IDLE: begin
            if (hdr_fire) begin
                state_next = hdr_sel_udp ? ARB_UDP : ARB_RAW;
            end
        end
        ARB_UDP,
        ARB_RAW: begin
            // Grant released only after the frame's last beat
            if (last_fire) begin
                state_next = ARB_IDLE;
            end
        end
        default: begin
            state_next = ARB_IDLE;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= ARB_IDLE;
    end else begin
        state <= state_next;
    end
end

endmodule

// ==== src/ip_proto_demux.sv ====
`timescale 1ns/100ps

module ip_proto_demux
    import udp_ip_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Frames from the IP stack
    input  logic       in_hdr_valid,
    output logic       in_hdr_ready,
    input  ip_dscp_t   in_dscp,
    input  ip_ecn_t    in_ecn,
    input  ip_len_t    in_length,
    input  ip_ttl_t    in_ttl,
    input  ip_proto_t  in_protocol,
    input  ip_addr_t   in_source_ip,
    input  ip_addr_t   in_dest_ip,
    input  axis_byte_t in_payload_tdata,
    input  logic       in_payload_tvalid,
    output logic       in_payload_tready,
    input  logic       in_payload_tlast,
    input  logic       in_payload_tuser,

    // UDP engine side
    output logic       udp_hdr_valid,
    input  logic       udp_hdr_ready,
    output logic       udp_payload_tvalid,
    input  logic       udp_payload_tready,

    // Raw IP user side
    output logic       raw_hdr_valid,
    input  logic       raw_hdr_ready,
    output logic       raw_payload_tvalid,
    input  logic       raw_payload_tready
);

demux_state_t state;
demux_state_t state_next;
logic         is_udp;
logic         hdr_fire;
logic         last_fire;

assign is_udp = (in_protocol == IP_PROTO_UDP);

// Strobe steering, header only in idle, payload only to the locked route
always_comb begin
    udp_hdr_valid      = 1'b0;
    raw_hdr_valid      = 1'b0;
    in_hdr_ready       = 1'b0;
    udp_payload_tvalid = 1'b0;
    raw_payload_tvalid = 1'b0;
    in_payload_tready  = 1'b0;
    case (state)
        DEMUX_IDLE: begin
            udp_hdr_valid = in_hdr_valid && is_udp;
            raw_hdr_valid = in_hdr_valid && !is_udp;
            in_hdr_ready  = is_udp ? udp_hdr_ready : raw_hdr_ready;
        end
        DEMUX_UDP: begin
            udp_payload_tvalid = in_payload_tvalid;
            in_payload_tready  = udp_payload_tready;
        end
        DEMUX_RAW: begin
            raw_payload_tvalid = in_payload_tvalid;
            in_payload_tready  = raw_payload_tready;
        end
        default: begin
            in_payload_tready = 1'b0;
        end
    endcase
end

assign hdr_fire  = in_hdr_valid && in_hdr_ready;
assign last_fire = in_payload_tvalid && in_payload_tready && in_payload_tlast;

// Route latched on header accept
always_comb begin
    state_next = state;
    case (state)
        DEMUX_IDLE: begin
            if (hdr_fire) begin
                state_next = is_udp ? DEMUX_UDP : DEMUX_RAW;
            end
        end
        DEMUX_UDP,
        DEMUX_RAW: begin
            if (last_fire) begin
                state_next = DEMUX_IDLE;
            end
        end
        default: begin
            state_next = DEMUX_IDLE;
        end
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        state <= DEMUX_IDLE;
    end else begin
        state <= state_next;
    end
end

endmodule

// ==== src/udp_ip_pkg.sv ====
package udp_ip_pkg;

// IPv4 header fields carried alongside each frame
typedef logic [31:0] ip_addr_t;
typedef logic [15:0] ip_len_t;
typedef logic [7:0]  ip_proto_t;
typedef logic [5:0]  ip_dscp_t;
typedef logic [1:0]  ip_ecn_t;
typedef logic [7:0]  ip_ttl_t;

// Payload stream is one byte per beat
typedef logic [7:0]  axis_byte_t;

localparam ip_proto_t IP_PROTO_UDP = 8'h11;

// Receive classifier, route held from header to tlast
typedef enum logic [1:0] {
    DEMUX_IDLE,
    DEMUX_UDP,
    DEMUX_RAW
} demux_state_t;

// Transmit arbiter, grant held from header to tlast
typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_UDP,
    ARB_RAW
} arb_state_t;

endpackage
